// File: compile.f
design/stream_pkg.sv
design/rr_arbiter.sv
design/sync_fifo.sv
design/read_request_gen.sv
design/read_data_router.sv
design/cgra_read_stream.sv
test/stream_assert.sv
test/stream_checker.sv
test/tb_cgra_read_stream.sv

// File: Bender.yml
package:
  name: cgra_read_stream

sources:
  - design/stream_pkg.sv
  - design/rr_arbiter.sv
  - design/sync_fifo.sv
  - design/read_request_gen.sv
  - design/read_data_router.sv
  - design/cgra_read_stream.sv
  - target: test
    files:
      - test/stream_assert.sv
      - test/stream_checker.sv
      - test/tb_cgra_read_stream.sv

// File: test/tb_cgra_read_stream.sv
//////////////////////////////
// Testbench of the CGRA read streamer
// Memory word at byte address a is a hash of a
// Node configs keep bases and strides multiples of 4
//////////////////////////////
`timescale 1ns/1ps

module tb_cgra_read_stream;
    import stream_pkg::*;

    localparam int unsigned SEED = 32'h6e8c;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      execute;
    node_cfg_t [NODES_NUM-1:0] node_cfg;
    logic [ADDR_W-1:0]         ar_addr;
    logic                      ar_valid;
    logic                      ar_ready = 1'b1;
    bus_word_t                 r_data = '0;
    logic                      r_valid = 1'b0;
    word_t [NODES_NUM-1:0]     node_data;
    node_mask_t                node_valid;
    node_mask_t                node_ready = '1;
    logic                      done;
    logic                      outst_full;
    logic                      stress_mode = 1'b0;
    logic                      full_seen = 1'b0;
    int                        watchdog_cycles = 0;
    int                        chk_tests;
    int                        chk_failed;
    int                        chk_errors;
    int                        errors;
    logic [ADDR_W-1:0]         addr_q [$];
    longint                    due_q [$];
    longint                    cycle = 0;
    longint                    last_due = 0;

    always #5 clk = ~clk;

    cgra_read_stream dut0 (
        .clk_i        ( clk        ),
        .rst_ni       ( rst_n      ),
        .execute_i    ( execute    ),
        .node_cfg_i   ( node_cfg   ),
        .ar_addr_o    ( ar_addr    ),
        .ar_valid_o   ( ar_valid   ),
        .ar_ready_i   ( ar_ready   ),
        .r_data_i     ( r_data     ),
        .r_valid_i    ( r_valid    ),
        .node_data_o  ( node_data  ),
        .node_valid_o ( node_valid ),
        .node_ready_i ( node_ready ),
        .done_o       ( done       ),
        .outst_full_o ( outst_full )
    );

    stream_checker chk0 (
        .clk_i        ( clk        ),
        .rst_ni       ( rst_n      ),
        .node_data_i  ( node_data  ),
        .node_valid_i ( node_valid ),
        .node_ready_i ( node_ready ),
        .tests_o      ( chk_tests  ),
        .failed_o     ( chk_failed ),
        .errors_o     ( chk_errors )
    );

    function automatic word_t mem_word(logic [ADDR_W-1:0] addr);
        logic [31:0] h;
        h = (addr ^ 32'h3c6e_f372) * 32'h9e37_79b1;
        return h ^ (h >> 15);
    endfunction

    function automatic bus_word_t mem_beat(logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] beat_addr;
        beat_addr = {addr[ADDR_W-1:3], 3'b000};
        return {mem_word(beat_addr + 4), mem_word(beat_addr)};
    endfunction

    // Word k of a node sits at base + k * stride
    function automatic word_t expected_word(node_cfg_t cfg, int k);
        return mem_word(cfg.base + ADDR_W'(k) * ADDR_W'(cfg.stride));
    endfunction

    // Words are fetched while k * stride < size
    function automatic int word_count(node_cfg_t cfg);
        int k = 0;
        while (k * int'(cfg.stride) < int'(cfg.size)) begin
            k++;
        end
        return k;
    endfunction

    // Memory model answering in order after 1 to 4 cycles
    always @(posedge clk) begin : memory_model
        longint due;
        cycle   = cycle + 1;
        r_valid <= 1'b0;
        if (!rst_n) begin
            addr_q.delete();
            due_q.delete();
        end else begin
            if (ar_valid && ar_ready) begin
                due = cycle + 1 + ($urandom % 4);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                addr_q.push_back(ar_addr);
                due_q.push_back(due);
            end
            // Stress mode returns a beat on about one cycle in three
            if (due_q.size() > 0 && due_q[0] <= cycle &&
                (!stress_mode || ($urandom % 3) == 0)) begin
                r_valid <= 1'b1;
                r_data  <= mem_beat(addr_q.pop_front());
                void'(due_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        if (stress_mode) begin
            node_ready <= node_mask_t'($urandom);
            ar_ready   <= 1'($urandom % 2);
        end else begin
            node_ready <= '1;
            ar_ready   <= 1'b1;
        end
        if (outst_full) begin
            full_seen <= 1'b1;
        end
    end

    task automatic run_test(input string name, input node_cfg_t [NODES_NUM-1:0] cfg,
                            input logic stress);
        chk0.start_test(name);
        for (int n = 0; n < NODES_NUM; n++) begin
            for (int k = 0; k < word_count(cfg[n]); k++) begin
                chk0.add_expected(n, expected_word(cfg[n], k));
            end
        end
        @(posedge clk);
        node_cfg    <= cfg;
        stress_mode <= stress;
        full_seen   <= 1'b0;
        @(posedge clk);
        execute <= 1'b1;
        @(posedge clk);
        execute <= 1'b0;
        @(posedge clk);
        chk0.check_value("done_o after execute_i", 1'b0, done);
        while (done !== 1'b1) begin
            @(posedge clk);
        end
        // Words may still wait in the node FIFOs
        while (node_valid !== '0) begin
            @(posedge clk);
        end
        if (stress && !full_seen) begin
            chk0.fail_check("outst_full_o was never high while the data channel was slow");
        end
        stress_mode <= 1'b0;
        repeat (2) @(posedge clk);
        chk0.end_test();
    endtask

    initial begin : stimulus
        node_cfg_t [NODES_NUM-1:0] cfg_aligned;
        node_cfg_t [NODES_NUM-1:0] cfg_upper;
        node_cfg_t [NODES_NUM-1:0] cfg_zero;
        int unsigned               seed_ret;
        int                        total;

        seed_ret = $urandom(SEED);
        rst_n    = 1'b0;
        execute  = 1'b0;
        node_cfg = '0;

        cfg_aligned[0] = '{base: 32'h0000_1000, size: 16'd64,  stride: 16'd8};
        cfg_aligned[1] = '{base: 32'h0000_2000, size: 16'd40,  stride: 16'd8};
        cfg_aligned[2] = '{base: 32'h0001_0000, size: 16'd100, stride: 16'd16};
        cfg_aligned[3] = '{base: 32'h8000_0000, size: 16'd200, stride: 16'd8};
        // Odd multiples of 4 land words in the upper half of a beat
        cfg_upper[0] = '{base: 32'h0000_3004, size: 16'd96,  stride: 16'd12};
        cfg_upper[1] = '{base: 32'h0000_400c, size: 16'd36,  stride: 16'd4};
        cfg_upper[2] = '{base: 32'h0000_5014, size: 16'd120, stride: 16'd20};
        cfg_upper[3] = '{base: 32'h0000_6ffc, size: 16'd90,  stride: 16'd28};
        cfg_zero         = cfg_upper;
        cfg_zero[2].size = '0;

        total = 0;
        for (int n = 0; n < NODES_NUM; n++) begin
            total += 2 * word_count(cfg_aligned[n]) + word_count(cfg_upper[n]) +
                     2 * word_count(cfg_zero[n]);
        end
        watchdog_cycles = 500 + 40 * total;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        chk0.start_test("reset_values");
        @(posedge clk);
        chk0.check_value("done_o", 1'b1, done);
        chk0.check_value("ar_valid_o", 1'b0, ar_valid);
        chk0.check_value("node_valid_o", '0, node_valid);
        chk0.check_value("outst_full_o", 1'b0, outst_full);
        chk0.end_test();

        run_test("aligned_ready", cfg_aligned, 1'b0);
        run_test("upper_half", cfg_upper, 1'b0);
        run_test("random_ready", cfg_aligned, 1'b1);
        run_test("zero_size", cfg_zero, 1'b0);
        run_test("rerun", cfg_zero, 1'b0);

        errors = chk_errors + dut0.stream_assert0.assert_errors;
        $display("Tests: %0d, failed: %0d, errors: %0d", chk_tests, chk_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("TIMEOUT: run still busy after %0d cycles", watchdog_cycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: test/stream_checker.sv
//////////////////////////////
// Scoreboard of the node streams
// Holds up to 128 expected words per node
//////////////////////////////
`timescale 1ns/1ps

module stream_checker (
    input  logic                                          clk_i,
    input  logic                                          rst_ni,
    input  stream_pkg::word_t [stream_pkg::NODES_NUM-1:0] node_data_i,
    input  stream_pkg::node_mask_t                        node_valid_i,
    input  stream_pkg::node_mask_t                        node_ready_i,
    output int                                            tests_o,
    output int                                            failed_o,
    output int                                            errors_o
);
    import stream_pkg::*;

    localparam int MAX_WORDS = 128;

    word_t exp_mem [NODES_NUM][MAX_WORDS];
    int    exp_count [NODES_NUM];
    int    got_count [NODES_NUM];
    string test_name = "idle";
    int    test_errors = 0;
    int    error_count = 0;
    int    test_count = 0;
    int    failed_count = 0;

    assign tests_o  = test_count;
    assign failed_o = failed_count;
    assign errors_o = error_count;

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        for (int n = 0; n < NODES_NUM; n++) begin
            exp_count[n] = 0;
            got_count[n] = 0;
        end
    endtask

    task automatic fail_check(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        test_errors++;
        error_count++;
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            test_errors++;
            error_count++;
        end
    endtask

    task automatic add_expected(input int node, input word_t word);
        if (exp_count[node] < MAX_WORDS) begin
            exp_mem[node][exp_count[node]] = word;
            exp_count[node]++;
        end else begin
            fail_check("too many expected words for one node");
        end
    endtask

    task automatic end_test();
        for (int n = 0; n < NODES_NUM; n++) begin
            check_value($sformatf("node %0d word count", n), 64'(exp_count[n]),
                        64'(got_count[n]));
        end
        test_count++;
        if (test_errors == 0) begin
            $display("TEST %s passed", test_name);
        end else begin
            failed_count++;
            $display("TEST %s failed with %0d errors", test_name, test_errors);
        end
    endtask

    // Every handshake is compared in order per node
    always @(posedge clk_i) begin
        if (rst_ni) begin
            for (int n = 0; n < NODES_NUM; n++) begin
                if (node_valid_i[n] && node_ready_i[n]) begin
                    if (got_count[n] >= exp_count[n]) begin
                        fail_check($sformatf("node %0d delivered an extra word %h",
                                             n, node_data_i[n]));
                    end else if (node_data_i[n] !== exp_mem[n][got_count[n]]) begin
                        $display("MISMATCH %s node %0d word %0d: expected %h, actual %h",
                                 test_name, n, got_count[n], exp_mem[n][got_count[n]],
                                 node_data_i[n]);
                        test_errors++;
                        error_count++;
                    end
                    got_count[n]++;
                end
            end
        end
    end

endmodule

// File: test/stream_assert.sv
//////////////////////////////
// AR channel and node FIFO checks
// Bound into cgra_read_stream
//////////////////////////////
`timescale 1ns/1ps

module stream_assert (
    input logic                                   clk_i,
    input logic                                   rst_ni,
    input logic [stream_pkg::ADDR_W-1:0]          ar_addr_i,
    input logic                                   ar_valid_i,
    input logic                                   ar_ready_i,
    input stream_pkg::node_mask_t                 node_push_i,
    input logic [stream_pkg::NODES_NUM-1:0][stream_pkg::NODE_LEVEL_W-1:0] node_level_i
);
    import stream_pkg::*;

    int assert_errors = 0;

    a_addr_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
        ar_valid_i && !ar_ready_i |=> $stable(ar_addr_i))
        else begin
            assert_errors++;
            $error("ar_addr_o changed while the read address was stalled");
        end

    a_addr_aligned : assert property (@(posedge clk_i) disable iff (!rst_ni)
        ar_valid_i |-> !$isunknown(ar_addr_i) && ar_addr_i[2:0] == 3'b000)
        else begin
            assert_errors++;
            $error("ar_addr_o is unknown or not 8-byte aligned");
        end

    for (genvar i = 0; i < NODES_NUM; i++) begin : g_node
        a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
            node_push_i[i] |-> node_level_i[i] < NODE_LEVEL_W'(NODE_FIFO_DEPTH))
            else begin
                assert_errors++;
                $error("word pushed into a full node FIFO");
            end
    end

endmodule

bind cgra_read_stream stream_assert stream_assert0 (
    .clk_i        ( clk_i                        ),
    .rst_ni       ( rst_ni                       ),
    .ar_addr_i    ( ar_addr_o                    ),
    .ar_valid_i   ( ar_valid_o                   ),
    .ar_ready_i   ( ar_ready_i                   ),
    .node_push_i  ( i_read_data_router.node_push ),
    .node_level_i ( node_level                   )
);

// File: design/cgra_read_stream.sv
//////////////////////////////
// Read-side memory streamer for a CGRA
// Start a run with a one-cycle execute_i
// done_o is high while no run is active
//////////////////////////////
`timescale 1ns/1ps

module cgra_read_stream (
    input  logic                                       clk_i,
    input  logic                                       rst_ni,
    input  logic                                       execute_i,
    input  stream_pkg::node_cfg_t [stream_pkg::NODES_NUM-1:0] node_cfg_i,
    output logic [stream_pkg::ADDR_W-1:0]              ar_addr_o,
    output logic                                       ar_valid_o,
    input  logic                                       ar_ready_i,
    input  stream_pkg::bus_word_t                      r_data_i,
    input  logic                                       r_valid_i,
    output stream_pkg::word_t [stream_pkg::NODES_NUM-1:0] node_data_o,
    output stream_pkg::node_mask_t                     node_valid_o,
    input  stream_pkg::node_mask_t                     node_ready_i,
    output logic                                       done_o,
    output logic                                       outst_full_o
);
    import stream_pkg::*;

    logic                                      issue;
    read_tag_t                                 issue_tag;
    logic [NODES_NUM-1:0][NODE_LEVEL_W-1:0]    node_level;
    logic                                      outst_empty;

    read_request_gen i_read_request_gen (
        .clk_i         ( clk_i        ),
        .rst_ni        ( rst_ni       ),
        .execute_i     ( execute_i    ),
        .node_cfg_i    ( node_cfg_i   ),
        .node_level_i  ( node_level   ),
        .outst_empty_i ( outst_empty  ),
        .outst_full_i  ( outst_full_o ),
        .ar_ready_i    ( ar_ready_i   ),
        .ar_addr_o     ( ar_addr_o    ),
        .ar_valid_o    ( ar_valid_o   ),
        .issue_o       ( issue        ),
        .issue_tag_o   ( issue_tag    ),
        .done_o        ( done_o       )
    );

    read_data_router i_read_data_router (
        .clk_i         ( clk_i        ),
        .rst_ni        ( rst_ni       ),
        .issue_i       ( issue        ),
        .issue_tag_i   ( issue_tag    ),
        .r_data_i      ( r_data_i     ),
        .r_valid_i     ( r_valid_i    ),
        .node_data_o   ( node_data_o  ),
        .node_valid_o  ( node_valid_o ),
        .node_ready_i  ( node_ready_i ),
        .node_level_o  ( node_level   ),
        .outst_empty_o ( outst_empty  ),
        .outst_full_o  ( outst_full_o )
    );

endmodule

// File: design/read_data_router.sv
//////////////////////////////
// Routes read beats to node FIFOs
// Beats must return in request order
// The read data side is always ready
//////////////////////////////
`timescale 1ns/1ps

module read_data_router (
    input  logic                                       clk_i,
    input  logic                                       rst_ni,
    input  logic                                       issue_i,
    input  stream_pkg::read_tag_t                      issue_tag_i,
    input  stream_pkg::bus_word_t                      r_data_i,
    input  logic                                       r_valid_i,
    output stream_pkg::word_t [stream_pkg::NODES_NUM-1:0] node_data_o,
    output stream_pkg::node_mask_t                     node_valid_o,
    input  stream_pkg::node_mask_t                     node_ready_i,
    output logic [stream_pkg::NODES_NUM-1:0][stream_pkg::NODE_LEVEL_W-1:0] node_level_o,
    output logic                                       outst_empty_o,
    output logic                                       outst_full_o
);
    import stream_pkg::*;

    read_tag_t  head_tag;
    word_t      beat_word;
    node_mask_t node_push;
    node_mask_t node_pop;
    node_mask_t node_empty;

    // Oldest tag belongs to the beat on the bus
    sync_fifo #(
        .DEPTH ( MAX_OUTSTANDING ),
        .dtype ( read_tag_t      )
    ) i_outst_fifo (
        .clk_i   ( clk_i         ),
        .rst_ni  ( rst_ni        ),
        .push_i  ( issue_i       ),
        .data_i  ( issue_tag_i   ),
        .pop_i   ( r_valid_i     ),
        .data_o  ( head_tag      ),
        .full_o  ( outst_full_o  ),
        .empty_o ( outst_empty_o ),
        .level_o (               )
    );

    assign beat_word = head_tag.upper_half ? r_data_i[BUS_W-1:WORD_W] : r_data_i[WORD_W-1:0];
    assign node_push = r_valid_i ? head_tag.node_mask : '0;

    assign node_valid_o = ~node_empty;
    assign node_pop     = node_valid_o & node_ready_i;

    for (genvar i = 0; i < NODES_NUM; i++) begin : g_node
        sync_fifo #(
            .DEPTH ( NODE_FIFO_DEPTH ),
            .dtype ( word_t          )
        ) i_node_fifo (
            .clk_i   ( clk_i           ),
            .rst_ni  ( rst_ni          ),
            .push_i  ( node_push[i]    ),
            .data_i  ( beat_word       ),
            .pop_i   ( node_pop[i]     ),
            .data_o  ( node_data_o[i]  ),
            .full_o  (                 ),
            .empty_o ( node_empty[i]   ),
            .level_o ( node_level_o[i] )
        );
    end

endmodule

// File: design/read_request_gen.sv
//////////////////////////////
// Read request side of the streamer
// node_cfg_i must stay stable during a run
// A zero stride with nonzero size never ends
//////////////////////////////
`timescale 1ns/1ps

module read_request_gen (
    input  logic                                       clk_i,
    input  logic                                       rst_ni,
    input  logic                                       execute_i,
    input  stream_pkg::node_cfg_t [stream_pkg::NODES_NUM-1:0] node_cfg_i,
    input  logic [stream_pkg::NODES_NUM-1:0][stream_pkg::NODE_LEVEL_W-1:0] node_level_i,
    input  logic                                       outst_empty_i,
    input  logic                                       outst_full_i,
    input  logic                                       ar_ready_i,
    output logic [stream_pkg::ADDR_W-1:0]              ar_addr_o,
    output logic                                       ar_valid_o,
    output logic                                       issue_o,
    output stream_pkg::read_tag_t                      issue_tag_o,
    output logic                                       done_o
);
    import stream_pkg::*;

    logic                              run_q;
    logic                              run_d;
    logic                              finish;

    // One spare bit so offset plus stride cannot wrap
    logic [NODES_NUM-1:0][SIZE_W:0]    offs_q;
    logic [NODES_NUM-1:0][SIZE_W:0]    offs_d;

    node_mask_t                        under_size;
    node_mask_t                        request;
    node_mask_t                        grant;
    logic                              arb_enable;

    logic                              ar_valid_q;
    logic                              ar_valid_d;
    logic                              ar_free;
    logic [ADDR_W-1:0]                 grant_addr;
    logic [ADDR_W-4:0]                 addr_hi_q;

    // Run control
    always_comb begin
        for (int i = 0; i < NODES_NUM; i++) begin
            under_size[i] = offs_q[i] < {1'b0, node_cfg_i[i].size};
            request[i]    = run_q && under_size[i] &&
                            (node_level_i[i] < NODE_LEVEL_W'(NODE_ROOM_LIMIT));
        end

        // All nodes at size and every read has returned
        finish = run_q && (under_size == '0) && outst_empty_i;
        run_d  = execute_i || (run_q && !finish);
    end

    // AR channel is free when idle or when the held address is taken
    assign ar_free    = !ar_valid_q || ar_ready_i;
    assign arb_enable = ar_free && !outst_full_i;
    assign issue_o    = (grant != '0);
    assign ar_valid_d = ar_free ? issue_o : ar_valid_q;

    always_comb begin
        grant_addr = '0;
        offs_d     = offs_q;

        // Grant is one-hot, so OR-ing the candidates selects one address
        for (int i = 0; i < NODES_NUM; i++) begin
            if (grant[i]) begin
                grant_addr = grant_addr | (node_cfg_i[i].base + ADDR_W'(offs_q[i]));
                offs_d[i]  = offs_q[i] + {1'b0, node_cfg_i[i].stride};
            end
        end

        if (finish) begin
            offs_d = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            run_q      <= 1'b0;
            ar_valid_q <= 1'b0;
            offs_q     <= '0;
        end else begin
            run_q      <= run_d;
            ar_valid_q <= ar_valid_d;
            offs_q     <= offs_d;
        end
    end

    // Only the 8-byte beat address goes out on the bus
    always_ff @(posedge clk_i) begin
        if (issue_o) begin
            addr_hi_q <= grant_addr[ADDR_W-1:3];
        end
    end

    assign ar_addr_o  = {addr_hi_q, 3'b000};
    assign ar_valid_o = ar_valid_q;
    assign done_o     = !run_q;

    // Bit 2 tells which 32-bit half of the beat holds the word
    assign issue_tag_o.node_mask  = grant;
    assign issue_tag_o.upper_half = grant_addr[2];

    rr_arbiter i_rr_arbiter (
        .clk_i     ( clk_i      ),
        .rst_ni    ( rst_ni     ),
        .enable_i  ( arb_enable ),
        .request_i ( request    ),
        .grant_o   ( grant      )
    );

endmodule

// File: design/sync_fifo.sv
//////////////////////////////
// Synchronous FIFO, any depth
// Push when full and pop when empty are ignored
// Head word is valid while not empty
//////////////////////////////
`timescale 1ns/1ps

module sync_fifo #(
    parameter int unsigned DEPTH = 4,
    parameter type         dtype = logic
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       push_i,
    input  dtype                       data_i,
    input  logic                       pop_i,
    output dtype                       data_o,
    output logic                       full_o,
    output logic                       empty_o,
    output logic [$clog2(DEPTH+1)-1:0] level_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    dtype                       mem_q [DEPTH];
    logic [PTR_W-1:0]           wr_ptr_q;
    logic [PTR_W-1:0]           rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0] level_q;
    logic                       do_push;
    logic                       do_pop;

    assign full_o  = (level_q == DEPTH);
    assign empty_o = (level_q == '0);
    assign level_o = level_q;
    assign data_o  = mem_q[rd_ptr_q];

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop keep the count
            if (do_push && !do_pop) begin
                level_q <= level_q + 1'b1;
            end else if (do_pop && !do_push) begin
                level_q <= level_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

// File: design/rr_arbiter.sv
//////////////////////////////
// Round-robin arbiter, one-hot grant
// Grants nothing while enable_i is low
//////////////////////////////
`timescale 1ns/1ps

module rr_arbiter (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   enable_i,
    input  stream_pkg::node_mask_t request_i,
    output stream_pkg::node_mask_t grant_o
);
    import stream_pkg::*;

    // Last grant rotated left by one, i.e. the first position to search
    node_mask_t                 ptr_q;
    node_mask_t                 ptr_d;
    logic [2*NODES_NUM-1:0]     double_req;
    logic [2*NODES_NUM-1:0]     double_grant;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ptr_q <= node_mask_t'(1);
        end else begin
            ptr_q <= ptr_d;
        end
    end

    always_comb begin
        // Subtracting the pointer clears the first request at or above it;
        // the doubled vector handles the wrap back to bit 0
        double_req   = {request_i, request_i};
        double_grant = double_req & ~(double_req - {{NODES_NUM{1'b0}}, ptr_q});

        if (enable_i) begin
            grant_o = double_grant[NODES_NUM-1:0] | double_grant[2*NODES_NUM-1:NODES_NUM];
        end else begin
            grant_o = '0;
        end

        if (grant_o != '0) begin
            ptr_d = {grant_o[NODES_NUM-2:0], grant_o[NODES_NUM-1]};
        end else begin
            ptr_d = ptr_q;
        end
    end

endmodule

// File: design/stream_pkg.sv
//////////////////////////////
// Shared widths and types of the CGRA read streamer
// Node words are 32 bits, read beats are 64 bits
//////////////////////////////
package stream_pkg;

    localparam int unsigned NODES_NUM       = 4;
    localparam int unsigned ADDR_W          = 32;
    localparam int unsigned SIZE_W          = 16;
    localparam int unsigned WORD_W          = 32;
    localparam int unsigned BUS_W           = 64;
    localparam int unsigned NODE_FIFO_DEPTH = 10;
    localparam int unsigned MAX_OUTSTANDING = 6;

    // Fill count width of a node FIFO
    localparam int unsigned NODE_LEVEL_W    = $clog2(NODE_FIFO_DEPTH + 1);

    // A node requests only below this fill level, so outstanding
    // reads always find room when they return
    localparam int unsigned NODE_ROOM_LIMIT = NODE_FIFO_DEPTH - MAX_OUTSTANDING;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [BUS_W-1:0]     bus_word_t;
    typedef logic [NODES_NUM-1:0] node_mask_t;

    // Fetch setup of one node, all fields in bytes
    typedef struct packed {
        logic [ADDR_W-1:0] base;
        logic [SIZE_W-1:0] size;
        logic [SIZE_W-1:0] stride;
    } node_cfg_t;

    // Remembered per issued read until its beat returns
    typedef struct packed {
        node_mask_t node_mask;
        logic       upper_half;
    } read_tag_t;

endpackage
